// ==== rtl/panel_pkg.sv ====
// status panel package: shared types, seven-segment glyph tables and default timing
package panel_pkg;

    localparam int N_DIGITS = 8;

    localparam int DEF_DIGIT_PERIOD = 16000;    // dwell per digit in core cycles
    localparam int DEF_LOAD_STEP    = 1 << 25;  // cycles per marquee frame
    localparam int DEF_PWM_BITS     = 12;

    typedef logic [7:0] seg_t;                  // {dp, a, b, c, d, e, f, g}, 1 = lit
    typedef logic [N_DIGITS-1:0] anode_t;       // one-cold at the pins
    typedef logic [2:0] digit_idx_t;
    typedef logic [3:0] frame_t;                // wraps mod 16

    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3
    } priv_t;

    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
        logic centre;
    } buttons_t;

    typedef struct packed {
        logic init_done;
        logic loading;
    } panel_status_t;

    typedef struct packed {
        seg_t   sg;     // active low at the pins
        anode_t an;
    } seg_drive_t;

    typedef struct packed {
        logic b;
        logic g;
        logic r;
    } rgb_t;

    // letters
    localparam seg_t SEG_BLANK = 8'b0000_0000;
    localparam seg_t SEG_DP    = 8'b1000_0000;
    localparam seg_t SEG_A     = 8'b0111_0111;
    localparam seg_t SEG_R     = 8'b0000_0101;
    localparam seg_t SEG_C     = 8'b0000_1101;
    localparam seg_t SEG_H     = 8'b0001_0111;
    localparam seg_t SEG_P     = 8'b0110_0111;
    localparam seg_t SEG_O     = 8'b0001_1101;
    localparam seg_t SEG_L     = 8'b0000_1110;
    localparam seg_t SEG_LA    = 8'b0111_1101;  // lower case a
    localparam seg_t SEG_D     = 8'b0011_1101;
    localparam seg_t SEG_I     = 8'b0001_0000;
    localparam seg_t SEG_N     = 8'b0001_0101;
    localparam seg_t SEG_G     = 8'b1111_1011;

    // banner reads "ArchProc" from digit 7 down to digit 0
    localparam seg_t BANNER_TBL [N_DIGITS] = '{
        SEG_C, SEG_O, SEG_R, SEG_P, SEG_H, SEG_C, SEG_R, SEG_A
    };

    localparam seg_t MARQUEE_TBL [16] = '{
        SEG_BLANK, SEG_BLANK, SEG_BLANK, SEG_BLANK, SEG_BLANK, SEG_BLANK, SEG_BLANK,
        SEG_L, SEG_O, SEG_LA, SEG_D, SEG_I, SEG_N, SEG_G, SEG_DP, SEG_DP
    };

    localparam seg_t HEX_TBL [16] = '{
        8'b0111_1110, 8'b0011_0000, 8'b0110_1101, 8'b0111_1001,
        8'b0011_0011, 8'b0101_1011, 8'b0101_1111, 8'b0111_0000,
        8'b0111_1111, 8'b0111_1011, 8'b0111_0111, 8'b0001_1111,
        8'b0100_1110, 8'b0011_1101, 8'b0100_1111, 8'b0100_0111
    };

endpackage

// ==== rtl/glyph_decoder.sv ====
// glyph decoder: hex nibble, banner letter and marquee slot to segment patterns
`timescale 1ns/1ps

module glyph_decoder (
    input  logic [3:0]            i_nibble,
    input  panel_pkg::digit_idx_t i_digit,
    input  panel_pkg::frame_t     i_frame,
    output panel_pkg::seg_t       o_hex,
    output panel_pkg::seg_t       o_banner,
    output panel_pkg::seg_t       o_marquee
);

    // marquee slot for this digit, 4-bit math wraps mod 16
    panel_pkg::frame_t w_slot;

    // digit 7 sits at the frame number, lower digits trail it
    assign w_slot = i_frame + 4'd7 - {1'b0, i_digit};

    assign o_hex     = panel_pkg::HEX_TBL[i_nibble];
    assign o_banner  = panel_pkg::BANNER_TBL[i_digit];
    assign o_marquee = panel_pkg::MARQUEE_TBL[w_slot];

endmodule

// ==== rtl/digit_scanner.sv ====
// digit scanner: multiplexes eight digits, steps the marquee and registers the pins
`timescale 1ns/1ps

module digit_scanner #(
    parameter int DIGIT_PERIOD = panel_pkg::DEF_DIGIT_PERIOD,
    parameter int LOAD_STEP    = panel_pkg::DEF_LOAD_STEP
) (
    input  logic                     CORE_CLK,
    input  logic                     CORE_RST_X,
    input  logic [31:0]              i_value,
    input  panel_pkg::panel_status_t i_status,
    output panel_pkg::seg_drive_t    o_seg
);

    localparam int DWELL_W = (DIGIT_PERIOD > 1) ? $clog2(DIGIT_PERIOD) : 1;
    localparam int STEP_W  = (LOAD_STEP > 1) ? $clog2(LOAD_STEP) : 1;

    logic [DWELL_W-1:0]    r_dwell;
    logic [STEP_W-1:0]     r_load_cnt;     // loading cycles mod LOAD_STEP
    panel_pkg::digit_idx_t r_digit;
    panel_pkg::frame_t     r_frame;
    panel_pkg::seg_t       r_hex;
    panel_pkg::seg_t       r_banner;
    panel_pkg::seg_t       r_marquee;
    panel_pkg::seg_drive_t r_drive;
    panel_pkg::seg_t       w_hex;
    panel_pkg::seg_t       w_banner;
    panel_pkg::seg_t       w_marquee;
    logic [3:0]            w_nibble;
    logic                  w_tick;

    assign w_tick   = (r_dwell == '0);
    assign w_nibble = i_value[{r_digit, 2'b00} +: 4];

    glyph_decoder u_glyph (
        .i_nibble  (w_nibble),
        .i_digit   (r_digit),
        .i_frame   (r_frame),
        .o_hex     (w_hex),
        .o_banner  (w_banner),
        .o_marquee (w_marquee)
    );

    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            r_dwell <= '0;
        end else if (r_dwell == DWELL_W'(DIGIT_PERIOD - 1)) begin
            r_dwell <= '0;
        end else begin
            r_dwell <= r_dwell + 1'b1;
        end
    end

    // marquee frame only moves while the image loads
    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            r_load_cnt <= '0;
            r_frame    <= '0;
        end else if (i_status.loading) begin
            if (r_load_cnt == STEP_W'(LOAD_STEP - 1)) begin
                r_load_cnt <= '0;
            end else begin
                r_load_cnt <= r_load_cnt + 1'b1;
            end
            if (r_load_cnt == '0) begin
                r_frame <= r_frame + 1'b1;
            end
        end
    end

    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            r_digit   <= '0;
            r_hex     <= '0;
            r_banner  <= '0;
            r_marquee <= '0;
            r_drive   <= '{sg: '1, an: '1};    // everything dark
        end else begin
            if (w_tick) begin
                r_digit    <= r_digit + 1'b1;
                r_drive.an <= ~(panel_pkg::anode_t'(1) << r_digit);  // old index
                r_hex      <= w_hex;
                r_banner   <= w_banner;
                r_marquee  <= w_marquee;
            end
            // segment select follows the anode by one cycle
            if (i_status.loading) begin
                r_drive.sg <= ~r_marquee;
            end else if (i_status.init_done) begin
                r_drive.sg <= ~r_hex;
            end else begin
                r_drive.sg <= ~r_banner;
            end
        end
    end

    assign o_seg = r_drive;

    // never two digits driven together
    a_anode_one_cold: assert property (@(posedge CORE_CLK) disable iff (!CORE_RST_X)
        $onehot(~o_seg.an) || (o_seg.an == '1));

endmodule

// ==== rtl/display_source.sv ====
// display source: keyboard and mouse byte history, button-selected display word, load flag
`timescale 1ns/1ps

module display_source (
    input  logic                      CORE_CLK,
    input  logic                      CORE_RST_X,
    input  logic                      i_kbd_we,
    input  logic [7:0]                i_kbd_data,
    input  logic                      i_mouse_we,
    input  logic [7:0]                i_mouse_data,
    input  panel_pkg::buttons_t       i_buttons,
    input  logic [31:0]               i_core_pc,
    input  logic [31:0]               i_core_ir,
    input  logic                      i_init_start,
    input  logic                      i_init_done,
    output logic [31:0]               o_value,
    output panel_pkg::panel_status_t  o_status
);

    logic [3:0][7:0]          r_hist;     // {mouse old, mouse new, kbd old, kbd new}
    logic [31:0]              w_sel;
    logic [31:0]              r_value;
    panel_pkg::panel_status_t r_status;

    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            r_hist <= '0;
        end else begin
            if (i_kbd_we) begin
                r_hist[0] <= i_kbd_data;
                r_hist[1] <= r_hist[0];
            end
            if (i_mouse_we) begin
                r_hist[2] <= i_mouse_data;
                r_hist[3] <= r_hist[2];
            end
        end
    end

    // up, down and centre all blank, then left, then right
    always_comb begin
        if (i_buttons.up || i_buttons.down || i_buttons.centre) begin
            w_sel = '0;
        end else if (i_buttons.left) begin
            w_sel = i_core_pc;
        end else if (i_buttons.right) begin
            w_sel = i_core_ir;
        end else begin
            w_sel = r_hist;
        end
    end

    always_ff @(posedge CORE_CLK) begin
        r_value <= w_sel;
    end

    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            r_status <= '0;
        end else begin
            r_status.init_done <= i_init_done;
            if (!r_status.loading && i_init_start && !i_init_done) begin
                r_status.loading <= 1'b1;
            end else if (i_init_done) begin
                r_status.loading <= 1'b0;
            end
        end
    end

    assign o_value  = r_value;
    assign o_status = r_status;

    a_kbd_known: assert property (@(posedge CORE_CLK) disable iff (!CORE_RST_X)
        i_kbd_we |-> !$isunknown(i_kbd_data));

    a_mouse_known: assert property (@(posedge CORE_CLK) disable iff (!CORE_RST_X)
        i_mouse_we |-> !$isunknown(i_mouse_data));

endmodule

// ==== rtl/privilege_led.sv ====
// privilege LED: breathing PWM while loading, blinking mode colour once running
`timescale 1ns/1ps

module privilege_led #(
    parameter int PWM_BITS = panel_pkg::DEF_PWM_BITS
) (
    input  logic                     CORE_CLK,
    input  logic                     CORE_RST_X,
    input  panel_pkg::panel_status_t i_status,
    input  panel_pkg::priv_t         i_priv,
    output panel_pkg::rgb_t          o_rgb
);

    localparam int PHASE_W = PWM_BITS + 1;
    // narrow counters lose the green offset
    localparam int G_INIT  = (PWM_BITS >= 6) ? 2 ** (PWM_BITS - 6) : 0;
    localparam int R_INIT  = 2 ** (PWM_BITS - 3);

    // channel order follows rgb_t bits: 0 red, 1 green, 2 blue
    localparam int PHASE_INIT [3] = '{R_INIT, G_INIT, 0};
    localparam int PHASE_STEP [3] = '{5, 3, 2};

    logic [PWM_BITS-1:0] r_pwm;
    logic [PHASE_W-1:0]  r_phase [3];
    logic [2:0]          r_breath;
    logic [3:0]          r_blink;      // lit only on count 0

    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            r_pwm    <= '0;
            r_blink  <= '0;
            r_breath <= '0;
            for (int c = 0; c < 3; c++) begin
                r_phase[c] <= PHASE_W'(PHASE_INIT[c]);
            end
        end else begin
            r_pwm   <= r_pwm + 1'b1;
            r_blink <= r_blink + 1'b1;
            for (int c = 0; c < 3; c++) begin
                if (r_pwm == '0) begin
                    r_phase[c] <= r_phase[c] + PHASE_W'(PHASE_STEP[c]);
                end
                // top phase bit picks rising or falling half of the breath
                if (r_phase[c][PWM_BITS]) begin
                    r_breath[c] <= (r_phase[c][PWM_BITS-1:0] < r_pwm);
                end else begin
                    r_breath[c] <= (r_phase[c][PWM_BITS-1:0] >= r_pwm);
                end
            end
        end
    end

    always_comb begin
        if (i_status.loading) begin
            o_rgb = panel_pkg::rgb_t'(r_breath);
        end else if (!i_status.init_done || (r_blink != '0)) begin
            o_rgb = '0;
        end else begin
            case (i_priv)
                panel_pkg::PRIV_U: o_rgb = '{b: 1'b1, g: 1'b0, r: 1'b0};
                panel_pkg::PRIV_S: o_rgb = '{b: 1'b0, g: 1'b1, r: 1'b0};
                panel_pkg::PRIV_M: o_rgb = '{b: 1'b0, g: 1'b0, r: 1'b1};
                default:           o_rgb = '0;  // reserved mode stays dark
            endcase
        end
    end

    // status comes registered from the display source
    a_single_colour: assert property (@(posedge CORE_CLK) disable iff (!CORE_RST_X)
        !i_status.loading |-> $onehot0(o_rgb));

endmodule

// ==== rtl/status_panel.sv ====
// status panel top: seven-segment display and privilege RGB LED of the SoC front panel
`timescale 1ns/1ps

module status_panel #(
    parameter int DIGIT_PERIOD = panel_pkg::DEF_DIGIT_PERIOD,
    parameter int LOAD_STEP    = panel_pkg::DEF_LOAD_STEP,
    parameter int PWM_BITS     = panel_pkg::DEF_PWM_BITS
) (
    input  logic                  CORE_CLK,
    input  logic                  CORE_RST_X,
    input  logic                  i_kbd_we,
    input  logic [7:0]            i_kbd_data,
    input  logic                  i_mouse_we,
    input  logic [7:0]            i_mouse_data,
    input  panel_pkg::buttons_t   i_buttons,
    input  logic [31:0]           i_core_pc,
    input  logic [31:0]           i_core_ir,
    input  logic                  i_init_start,
    input  logic                  i_init_done,
    input  panel_pkg::priv_t      i_priv,
    output panel_pkg::seg_drive_t o_seg,
    output panel_pkg::rgb_t       o_rgb
);

    logic [31:0]              w_value;
    panel_pkg::panel_status_t w_status;   // shared by scanner and LED

    display_source u_source (
        .CORE_CLK     (CORE_CLK),
        .CORE_RST_X   (CORE_RST_X),
        .i_kbd_we     (i_kbd_we),
        .i_kbd_data   (i_kbd_data),
        .i_mouse_we   (i_mouse_we),
        .i_mouse_data (i_mouse_data),
        .i_buttons    (i_buttons),
        .i_core_pc    (i_core_pc),
        .i_core_ir    (i_core_ir),
        .i_init_start (i_init_start),
        .i_init_done  (i_init_done),
        .o_value      (w_value),
        .o_status     (w_status)
    );

    digit_scanner #(
        .DIGIT_PERIOD (DIGIT_PERIOD),
        .LOAD_STEP    (LOAD_STEP)
    ) u_scanner (
        .CORE_CLK   (CORE_CLK),
        .CORE_RST_X (CORE_RST_X),
        .i_value    (w_value),
        .i_status   (w_status),
        .o_seg      (o_seg)
    );

    privilege_led #(
        .PWM_BITS (PWM_BITS)
    ) u_led (
        .CORE_CLK   (CORE_CLK),
        .CORE_RST_X (CORE_RST_X),
        .i_status   (w_status),
        .i_priv     (i_priv),
        .o_rgb      (o_rgb)
    );

endmodule

// ==== tb/panel_checks.svh ====
// panel reference model with expected display word, glyphs and LED colour and typed compare tasks
`ifndef PANEL_CHECKS_SVH
`define PANEL_CHECKS_SVH

// word the display register takes on the next edge
function automatic logic [31:0] select_display_word(panel_pkg::buttons_t b,
                                                    logic [31:0] pc,
                                                    logic [31:0] ir,
                                                    logic [31:0] hist);
    logic [31:0] word;
    if (b.up || b.down || b.centre) begin
        word = 32'd0;                       // blanking buttons win
    end else if (b.left) begin
        word = pc;
    end else if (b.right) begin
        word = ir;
    end else begin
        word = hist;
    end
    return word;
endfunction

function automatic panel_pkg::anode_t anode_for(panel_pkg::digit_idx_t digit);
    panel_pkg::anode_t an;
    an        = '1;
    an[digit] = 1'b0;                       // only the scanned digit pulled low
    return an;
endfunction

// one breathing channel with its half picked by the top phase bit
function automatic logic breath_level(logic [PHASE_W-1:0] phase, logic [PWM_BITS-1:0] pwm);
    logic lit;
    if (phase[PWM_BITS]) begin
        lit = (phase[PWM_BITS-1:0] < pwm);
    end else begin
        lit = (phase[PWM_BITS-1:0] >= pwm);
    end
    return lit;
endfunction

function automatic panel_pkg::seg_t expect_seg(panel_pkg::panel_status_t mode,
                                               logic [31:0] value,
                                               panel_pkg::digit_idx_t digit,
                                               panel_pkg::frame_t frame);
    panel_pkg::frame_t slot;
    panel_pkg::seg_t glyph;
    slot = panel_pkg::frame_t'((int'(frame) + 7 - int'(digit)) % 16);
    if (mode.loading) begin
        glyph = panel_pkg::MARQUEE_TBL[slot];
    end else if (mode.init_done) begin
        glyph = panel_pkg::HEX_TBL[value[int'(digit) * 4 +: 4]];
    end else begin
        glyph = panel_pkg::BANNER_TBL[digit];
    end
    return glyph;
endfunction

function automatic panel_pkg::rgb_t expect_rgb(panel_pkg::panel_status_t status,
                                               panel_pkg::priv_t priv,
                                               logic [3:0] blink,
                                               panel_pkg::rgb_t breath);
    panel_pkg::rgb_t colour;
    colour = '0;
    if (status.loading) begin
        colour = breath;
    end else if (status.init_done && (blink == 4'd0)) begin
        case (priv)
            panel_pkg::PRIV_U: colour.b = 1'b1;
            panel_pkg::PRIV_S: colour.g = 1'b1;
            panel_pkg::PRIV_M: colour.r = 1'b1;
            default:           colour = '0;
        endcase
    end
    return colour;
endfunction

task automatic check_seg(string name, panel_pkg::seg_t got, panel_pkg::seg_t exp);
    if (got !== exp) begin
        $display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp);
        abort_run();
    end
endtask

task automatic check_anode(string name, panel_pkg::anode_t got, panel_pkg::anode_t exp);
    if (got !== exp) begin
        $display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp);
        abort_run();
    end
endtask

task automatic check_rgb(string name, panel_pkg::rgb_t got, panel_pkg::rgb_t exp);
    if (got !== exp) begin
        $display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp);
        abort_run();
    end
endtask

`endif

// ==== tb/tb_status_panel.sv ====
// status panel testbench that drives the panel inputs and checks display and LED against a model
`timescale 1ns/1ps

module tb_status_panel;

    localparam int DIGIT_PERIOD = 4;
    localparam int LOAD_STEP    = 64;
    localparam int PWM_BITS     = 4;
    localparam int PHASE_W      = PWM_BITS + 1;
    // fractional green offset rounds down to zero on narrow counters
    localparam int GREEN_START  = (PWM_BITS >= 6) ? (1 << (PWM_BITS - 6)) : 0;
    localparam int RED_START    = 1 << (PWM_BITS - 3);

    localparam int BANNER_CYCLES  = 48;
    localparam int LOAD_CYCLES    = 320;
    localparam int HIST_CYCLES    = 256;
    localparam int BUTTON_CYCLES  = 40;
    localparam int N_BUTTON_CASES = 8;
    localparam int PRIV_CYCLES    = 48;
    localparam int TEST_CYCLES    = 16 + BANNER_CYCLES + 1 + LOAD_CYCLES + HIST_CYCLES + 1
                                  + N_BUTTON_CASES * BUTTON_CYCLES + 3 * PRIV_CYCLES;
    localparam int CYCLE_LIMIT    = 18 * TEST_CYCLES;   // wide margin over the script

    // bits are {up, down, left, right, centre}
    localparam panel_pkg::buttons_t BUTTON_CASES [N_BUTTON_CASES] = '{
        5'b00100, 5'b00010, 5'b00110, 5'b10100, 5'b01010, 5'b00111, 5'b10000, 5'b00000
    };

    logic                  CORE_CLK;
    logic                  CORE_RST_X;
    logic                  i_kbd_we;
    logic [7:0]            i_kbd_data;
    logic                  i_mouse_we;
    logic [7:0]            i_mouse_data;
    panel_pkg::buttons_t   i_buttons;
    logic [31:0]           i_core_pc;
    logic [31:0]           i_core_ir;
    logic                  i_init_start;
    logic                  i_init_done;
    panel_pkg::priv_t      i_priv;
    panel_pkg::seg_drive_t o_seg;
    panel_pkg::rgb_t       o_rgb;

    integer seed;
    int     cycle_count;

    // m_ holds the model after the last edge and p_ the model after the edge before
    logic [3:0][7:0]          m_hist;
    logic [31:0]              m_value;
    logic [31:0]              p_value;
    panel_pkg::panel_status_t m_status;
    panel_pkg::panel_status_t p_status;
    panel_pkg::frame_t        m_frame;
    panel_pkg::frame_t        p_frame;
    int                       m_load_cnt;
    logic [PWM_BITS-1:0]      m_pwm;
    logic [PHASE_W-1:0]       m_phase_b;
    logic [PHASE_W-1:0]       m_phase_g;
    logic [PHASE_W-1:0]       m_phase_r;
    panel_pkg::rgb_t          m_breath;
    logic [3:0]               m_blink;
    logic                     model_valid;
    logic                     was_reset;

    // scan tracking
    panel_pkg::anode_t        last_an;
    panel_pkg::digit_idx_t    next_digit;
    panel_pkg::digit_idx_t    shown_digit;
    logic [31:0]              latch_value;
    panel_pkg::frame_t        latch_frame;
    int                       dwell;

    task automatic abort_run();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    `include "panel_checks.svh"

    status_panel #(
        .DIGIT_PERIOD (DIGIT_PERIOD),
        .LOAD_STEP    (LOAD_STEP),
        .PWM_BITS     (PWM_BITS)
    ) dut (
        .CORE_CLK     (CORE_CLK),
        .CORE_RST_X   (CORE_RST_X),
        .i_kbd_we     (i_kbd_we),
        .i_kbd_data   (i_kbd_data),
        .i_mouse_we   (i_mouse_we),
        .i_mouse_data (i_mouse_data),
        .i_buttons    (i_buttons),
        .i_core_pc    (i_core_pc),
        .i_core_ir    (i_core_ir),
        .i_init_start (i_init_start),
        .i_init_done  (i_init_done),
        .i_priv       (i_priv),
        .o_seg        (o_seg),
        .o_rgb        (o_rgb)
    );

    initial begin
        CORE_CLK = 1'b0;
        forever begin
            #5 CORE_CLK = ~CORE_CLK;
        end
    end

    task automatic compare_outputs();
        panel_pkg::seg_t exp_glyph;
        if (model_valid && was_reset) begin
            check_anode("o_seg.an", o_seg.an, '1);
            check_seg("o_seg.sg", o_seg.sg, '1);
            check_rgb("o_rgb", o_rgb, '0);
            last_an    = '1;
            next_digit = '0;
            dwell      = 0;
        end else if (model_valid) begin
            check_rgb("o_rgb", o_rgb, expect_rgb(m_status, i_priv, m_blink, m_breath));
            if (o_seg.an != last_an) begin
                check_anode("o_seg.an", o_seg.an, anode_for(next_digit));
                shown_digit = next_digit;
                next_digit  = next_digit + 3'd1;
                latch_value = p_value;      // glyphs latched on the edge before
                latch_frame = p_frame;
                last_an     = o_seg.an;
                dwell       = 1;
            end else begin
                dwell = dwell + 1;
            end
            if (dwell > DIGIT_PERIOD) begin
                $display("digit scan stalled on digit %0d at time %0t", shown_digit, $time);
                abort_run();
            end
            if (dwell >= 2) begin
                exp_glyph = expect_seg(p_status, latch_value, shown_digit, latch_frame);
                check_seg("o_seg.sg", o_seg.sg, ~exp_glyph);
            end
        end
    endtask

    task automatic advance_model();
        p_value  = m_value;
        p_frame  = m_frame;
        p_status = m_status;
        m_value  = select_display_word(i_buttons, i_core_pc, i_core_ir, m_hist);
        if (!CORE_RST_X) begin
            m_hist      = '0;
            m_status    = '0;
            m_frame     = '0;
            m_load_cnt  = 0;
            m_pwm       = '0;
            m_phase_b   = '0;
            m_phase_g   = PHASE_W'(GREEN_START);
            m_phase_r   = PHASE_W'(RED_START);
            m_breath    = '0;
            m_blink     = '0;
            was_reset   = 1'b1;
            model_valid = 1'b1;
        end else begin
            was_reset = 1'b0;
            if (m_status.loading) begin
                if (m_load_cnt == 0) begin
                    m_frame = m_frame + 4'd1;
                end
                m_load_cnt = (m_load_cnt + 1) % LOAD_STEP;
            end
            if (i_kbd_we) begin
                m_hist[1] = m_hist[0];
                m_hist[0] = i_kbd_data;
            end
            if (i_mouse_we) begin
                m_hist[3] = m_hist[2];
                m_hist[2] = i_mouse_data;
            end
            if (i_init_start && !i_init_done) begin
                m_status.loading = 1'b1;
            end else if (i_init_done) begin
                m_status.loading = 1'b0;
            end
            m_status.init_done = i_init_done;
            m_breath.b = breath_level(m_phase_b, m_pwm);
            m_breath.g = breath_level(m_phase_g, m_pwm);
            m_breath.r = breath_level(m_phase_r, m_pwm);
            if (m_pwm == '0) begin
                m_phase_b = m_phase_b + PHASE_W'(2);
                m_phase_g = m_phase_g + PHASE_W'(3);
                m_phase_r = m_phase_r + PHASE_W'(5);
            end
            m_pwm   = m_pwm + 1'b1;
            m_blink = m_blink + 4'd1;
        end
    endtask

    // outputs read before this edge updates them
    always @(posedge CORE_CLK) begin
        compare_outputs();
        advance_model();
    end

    task automatic random_history(int cycles);
        repeat (cycles) begin
            @(negedge CORE_CLK);
            i_kbd_we     = (($random(seed) & 3) == 0);
            i_kbd_data   = 8'($random(seed));
            i_mouse_we   = (($random(seed) & 3) == 0);
            i_mouse_data = 8'($random(seed));
        end
        @(negedge CORE_CLK);
        i_kbd_we   = 1'b0;
        i_mouse_we = 1'b0;
    endtask

    task automatic hold_buttons(panel_pkg::buttons_t b, int cycles);
        repeat (cycles) begin
            @(negedge CORE_CLK);
            i_buttons = b;
            i_core_pc = 32'($random(seed));
            i_core_ir = 32'($random(seed));
        end
    endtask

    task automatic show_privilege(panel_pkg::priv_t p, int cycles);
        i_priv = p;
        repeat (cycles) @(negedge CORE_CLK);
    endtask

    initial begin
        int n;
        seed         = 27236;
        model_valid  = 1'b0;
        was_reset    = 1'b0;
        m_hist       = '0;
        m_value      = '0;
        m_status     = '0;
        m_frame      = '0;
        CORE_RST_X   = 1'b0;
        i_kbd_we     = 1'b0;
        i_kbd_data   = 8'd0;
        i_mouse_we   = 1'b0;
        i_mouse_data = 8'd0;
        i_buttons    = '0;
        i_core_pc    = 32'd0;
        i_core_ir    = 32'd0;
        i_init_start = 1'b0;
        i_init_done  = 1'b0;
        i_priv       = panel_pkg::PRIV_U;
        repeat (16) @(negedge CORE_CLK);
        CORE_RST_X = 1'b1;
        repeat (BANNER_CYCLES) @(negedge CORE_CLK);    // banner until init
        i_init_start = 1'b1;
        @(negedge CORE_CLK);
        i_init_start = 1'b0;
        repeat (LOAD_CYCLES) @(negedge CORE_CLK);      // marquee and breathing
        i_init_done = 1'b1;
        random_history(HIST_CYCLES);
        for (n = 0; n < N_BUTTON_CASES; n++) begin
            hold_buttons(BUTTON_CASES[n], BUTTON_CYCLES);
        end
        show_privilege(panel_pkg::PRIV_U, PRIV_CYCLES);
        show_privilege(panel_pkg::PRIV_S, PRIV_CYCLES);
        show_privilege(panel_pkg::PRIV_M, PRIV_CYCLES);
        $display("Result: PASSED");
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge CORE_CLK);
            cycle_count = cycle_count + 1;
        end
        $display("timeout: test did not finish within %0d cycles", CYCLE_LIMIT);
        abort_run();
    end

endmodule

// ==== status_panel.f ====
rtl/panel_pkg.sv
rtl/glyph_decoder.sv
rtl/digit_scanner.sv
rtl/display_source.sv
rtl/privilege_led.sv
rtl/status_panel.sv
tb/tb_status_panel.sv
+incdir+tb

// ==== run_sim.sh ====
#!/bin/sh
# compile the panel testbench with Verilator, run it, judge the run from its log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module tb_status_panel \
    -f status_panel.f \
    -o tb_status_panel \
    || { echo "build failed"; exit 1; }

./obj_dir/tb_status_panel > sim.log 2>&1
cat sim.log

grep -qx "Result: PASSED" sim.log && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }
